/* sim.f */
hdl/cache_pkg.sv
hdl/cache_ctrl.sv
hdl/tag_store.sv
hdl/victim_select.sv
hdl/data_store.sv
hdl/cache_top.sv
bench/cache_checker.sv
bench/cache_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module cache_tb -f sim.f -o cache_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/cache_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Finished with no errors"; then
	exit 0
fi
exit 1

/* bench/cache_tb.sv */
// cache testbench top, applies a table of Wishbone reads and writes with hand-worked results
module cache_tb;
	timeunit 1ns;
	timeprecision 1ps;

	typedef struct packed {
		cache_pkg::assoc_mode_t mode;
		logic                   we;
		logic [31:0]            addr;
		logic [31:0]            wdata;
		logic                   exp_hit;
		logic [31:0]            exp_data; // compared on reads only
	} entry_t;

	logic                   clk;
	logic                   reset;
	cache_pkg::assoc_mode_t assoc_mode;
	logic                   cyc;
	logic                   stb;
	logic                   we;
	logic [31:0]            adr;
	logic [31:0]            dat_w;
	logic [31:0]            dat_r;
	logic                   ack;
	logic                   hit;
	logic                   miss;
	logic                   exp_hit;
	logic [31:0]            exp_data;
	int                     errors;
	int                     checks;
	int                     cycles = 0;
	int                     cycle_limit = 0;
	entry_t                 table_q[$];
	cache_pkg::assoc_mode_t table_mode;

	cache_top dut0 (.*);

	cache_checker checker0 (.*);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic add_read(input logic [31:0] addr, input logic hit_exp, input logic [31:0] data_exp);
		entry_t e;
		e = '{table_mode, 1'b0, addr, 32'h0, hit_exp, data_exp};
		table_q.push_back(e);
	endtask

	task automatic add_write(input logic [31:0] addr, input logic [31:0] data, input logic hit_exp);
		entry_t e;
		e = '{table_mode, 1'b1, addr, data, hit_exp, 32'h0};
		table_q.push_back(e);
	endtask

	task automatic build_table();
		table_mode = cache_pkg::mode_1way;
		add_read(32'h0000_1230, 1'b0, 32'h0);                // set 0x23 tag 0x4
		add_write(32'h0000_1230, 32'ha5a5_0001, 1'b1);
		add_read(32'h0000_1230, 1'b1, 32'ha5a5_0001);
		add_read(32'h0000_5230, 1'b0, 32'h0);                // same set, tag 0x14 evicts
		add_read(32'h0000_1230, 1'b0, 32'h0);
		// four words of set 0 tag 8
		add_read(32'h0000_2000, 1'b0, 32'h0);
		for (int w = 0; w < 4; w++)
			add_write(32'h0000_2000 + 32'(w * 4), 32'h1111_0000 * 32'(w + 1) + 32'(w), 1'b1);
		for (int w = 0; w < 4; w++)
			add_read(32'h0000_2000 + 32'(w * 4), 1'b1, 32'h1111_0000 * 32'(w + 1) + 32'(w));

		table_mode = cache_pkg::mode_2way;
		add_write(32'h0000_0040, 32'h5a5a_0040, 1'b0);       // set 4 tag 0, way 0
		add_write(32'h0000_0240, 32'h5a5a_0240, 1'b0);       // set 4 tag 1, way 1
		add_read(32'h0000_0040, 1'b1, 32'h5a5a_0040);
		add_read(32'h0000_0240, 1'b1, 32'h5a5a_0240);

		// set 2, tag t sits at t * 0x80
		table_mode = cache_pkg::mode_8way;
		for (int t = 1; t <= 8; t++)
			add_write(32'h20 + 32'(t) * 32'h80, 32'hb000_0000 + 32'(t), 1'b0);
		add_read(32'h0000_00a0, 1'b1, 32'hb000_0001);        // way 0 count 3
		add_read(32'h0000_00a0, 1'b1, 32'hb000_0001);
		for (int t = 2; t <= 7; t++)
			add_read(32'h20 + 32'(t) * 32'h80, 1'b1, 32'hb000_0000 + 32'(t));
		add_read(32'h0000_04a0, 1'b0, 32'h0);                // way 7 has count 1
		add_read(32'h0000_0420, 1'b0, 32'h0);
		add_read(32'h0000_00a0, 1'b1, 32'hb000_0001);

		table_mode = cache_pkg::mode_4way;
		for (int t = 1; t <= 4; t++)
			add_read(32'h10 + 32'(t) * 32'h100, 1'b0, 32'h0); // set 1, ways 0 to 3
		add_read(32'h0000_0510, 1'b0, 32'h0);                // all counts 1, way 0 goes
		add_read(32'h0000_0110, 1'b0, 32'h0);
		add_read(32'h0000_0210, 1'b1, 32'h0);
		add_write(32'h0000_7038, 32'hc0de_0006, 1'b0);       // set 3 word 2
		add_read(32'h0000_7038, 1'b1, 32'hc0de_0006);
		add_read(32'h0000_7030, 1'b1, 32'h0);
		add_read(32'h0000_7034, 1'b1, 32'h0);
		add_read(32'h0000_703c, 1'b1, 32'h0);
	endtask

	function automatic logic starts_mode(input int i);
		return i == 0 || table_q[i].mode != table_q[i - 1].mode;
	endfunction

	task automatic hold_reset(input cache_pkg::assoc_mode_t mode);
		reset      = 1'b0;
		assoc_mode = mode; // mode only moves under reset
		repeat (16) @(negedge clk);
		reset = 1'b1;
	endtask

	task automatic run_entry(input entry_t e);
		@(negedge clk);
		exp_hit  = e.exp_hit;
		exp_data = e.exp_data;
		we       = e.we;
		adr      = e.addr;
		dat_w    = e.wdata;
		cyc      = 1'b1;
		stb      = 1'b1;
		do
			@(negedge clk);
		while (ack !== 1'b1);
		cyc = 1'b0;
		stb = 1'b0;
	endtask

	initial
	begin
		int resets;
		$timeformat(-9, 0, " ns", 0);
		reset      = 1'b0;
		assoc_mode = cache_pkg::mode_1way;
		cyc        = 1'b0;
		stb        = 1'b0;
		we         = 1'b0;
		adr        = 32'h0;
		dat_w      = 32'h0;
		exp_hit    = 1'b0;
		exp_data   = 32'h0;
		build_table();
		resets = 0;
		foreach (table_q[i])
			if (starts_mode(i))
				resets++;
		cycle_limit = table_q.size() * 8 + 16 * resets + 100;
		foreach (table_q[i])
		begin
			if (starts_mode(i))
				hold_reset(table_q[i].mode);
			run_entry(table_q[i]);
		end
		@(negedge clk);
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	initial
	begin
		wait (cycle_limit != 0);
		while (cycles < cycle_limit)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout, the test did not finish within %0d cycles", cycle_limit);
		$display("Finished with errors");
		$finish;
	end

endmodule

/* bench/cache_checker.sv */
// watches the cache bus and status outputs and compares each acknowledge with the expected values
module cache_checker (
	input  logic                   clk,
	input  logic                   reset,
	input  cache_pkg::assoc_mode_t assoc_mode,
	input  logic                   cyc,
	input  logic                   stb,
	input  logic                   we,
	input  logic [31:0]            adr,
	input  logic [31:0]            dat_r,
	input  logic                   ack,
	input  logic                   hit,
	input  logic                   miss,
	input  logic                   exp_hit,
	input  logic [31:0]            exp_data,
	output int                     errors,
	output int                     checks
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int ack_limit = 8; // a miss needs four edges

	int err_count = 0;
	int ack_count = 0;
	int wait_cycles = 0;

	assign errors = err_count;
	assign checks = ack_count;

	// set and tag as the active mode splits the address
	function automatic string describe_addr(input logic [31:0] a);
		cache_pkg::cache_addr_u view;
		view.raw = a;
		case (assoc_mode)
			cache_pkg::mode_1way: return $sformatf("set %0d tag %h", view.v1.set_index, view.v1.tag);
			cache_pkg::mode_2way: return $sformatf("set %0d tag %h", view.v2.set_index, view.v2.tag);
			cache_pkg::mode_4way: return $sformatf("set %0d tag %h", view.v4.set_index, view.v4.tag);
			default:              return $sformatf("set %0d tag %h", view.v8.set_index, view.v8.tag);
		endcase
	endfunction

	task automatic check_response();
		ack_count++;
		wait_cycles = 0;
		if (hit && miss)
		begin
			$display("hit and miss were both set with the acknowledge at %0t", $time);
			err_count++;
		end
		else if (hit !== exp_hit || miss !== ~exp_hit)
		begin
			$display("ERR %0t: adr %h (%s) we %b gave hit %b miss %b, expected hit %b",
				$time, adr, describe_addr(adr), we, hit, miss, exp_hit);
			err_count++;
		end
		if (!we && dat_r !== exp_data)
		begin
			$display("ERR %0t: read of %h (%s) returned %h, expected %h",
				$time, adr, describe_addr(adr), dat_r, exp_data);
			err_count++;
		end
	endtask

	// sample after the DUT edge, half a cycle away from the bench's drive edge
	always @(posedge clk)
	begin
		#1;
		if (!reset)
		begin
			wait_cycles = 0;
			if (ack || hit || miss)
			begin
				$display("ack, hit or miss was set while reset was held at %0t", $time);
				err_count++;
			end
		end
		else if (ack)
		begin
			if (!(cyc && stb))
			begin
				$display("acknowledge without a request at %0t", $time);
				err_count++;
			end
			check_response();
		end
		else
		begin
			if (hit || miss)
			begin
				$display("hit or miss was set without an acknowledge at %0t", $time);
				err_count++;
			end
			wait_cycles = (cyc && stb) ? wait_cycles + 1 : 0;
			if (wait_cycles == ack_limit)
			begin
				$display("no acknowledge for address %h after %0d cycles", adr, ack_limit);
				err_count++;
			end
		end
	end

endmodule

/* hdl/cache_top.sv */
// cache lookup block top level, a Wishbone classic slave serving one word per request
module cache_top (
	input  logic                   clk,
	input  logic                   reset,
	input  cache_pkg::assoc_mode_t assoc_mode, // change only while reset is held
	input  logic                   cyc,
	input  logic                   stb,
	input  logic                   we,
	input  logic [31:0]            adr,
	input  logic [31:0]            dat_w,
	output logic [31:0]            dat_r,
	output logic                   ack,
	output logic                   hit,
	output logic                   miss
);

	cache_pkg::cache_addr_u                     req_addr;
	logic [cache_pkg::word_bits-1:0]            req_data;
	cache_pkg::lookup_t                         lookup;
	cache_pkg::way_state_t                      ways;
	logic [cache_pkg::way_idx_bits-1:0]         victim_way;
	cache_pkg::update_t                         update;

	cache_ctrl ctrl0 (
		.clk        (clk),
		.reset      (reset),
		.cyc        (cyc),
		.stb        (stb),
		.we         (we),
		.adr        (adr),
		.dat_w      (dat_w),
		.ack        (ack),
		.hit        (hit),
		.miss       (miss),
		.req_addr   (req_addr),
		.req_data   (req_data),
		.lookup     (lookup),
		.victim_way (victim_way),
		.update     (update)
	);

	tag_store tags0 (
		.clk        (clk),
		.reset      (reset),
		.assoc_mode (assoc_mode),
		.req_addr   (req_addr),
		.update     (update),
		.lookup     (lookup),
		.ways       (ways)
	);

	victim_select victim0 (
		.assoc_mode (assoc_mode),
		.ways       (ways),
		.victim_way (victim_way)
	);

	data_store data0 (
		.clk        (clk),
		.assoc_mode (assoc_mode),
		.req_addr   (req_addr),
		.req_data   (req_data),
		.lookup     (lookup),
		.update     (update),
		.dat_r      (dat_r)
	);

endmodule

/* hdl/data_store.sv */
// line data of all ways, word read on a hit and word or zero-line write on update
module data_store (
	input  logic                              clk,
	input  cache_pkg::assoc_mode_t            assoc_mode,
	input  cache_pkg::cache_addr_u            req_addr,
	input  logic [cache_pkg::word_bits-1:0]   req_data,
	input  cache_pkg::lookup_t                lookup,
	input  cache_pkg::update_t                update,
	output logic [cache_pkg::word_bits-1:0]   dat_r
);

	logic [cache_pkg::words_per_line-1:0][cache_pkg::word_bits-1:0]
		line_mem [cache_pkg::num_ways][cache_pkg::lines_per_way];

	logic [cache_pkg::words_per_line-1:0][cache_pkg::word_bits-1:0] new_line;
	logic [1:0] word_sel;
	logic       line_we;

	assign word_sel = req_addr.v1.word_off; // same address bits in every mode view

	always_comb
	begin
		if (update.fill)
			new_line = '0; // zero-fill on allocate
		else
			new_line = line_mem[update.way][lookup.set_index];
		if (update.we)
			new_line[word_sel] = req_data;
	end

	assign line_we = update.do_update && (update.fill || update.we);

	always_ff @(posedge clk)
	begin
		if (line_we)
			line_mem[update.way][lookup.set_index] <= new_line;
	end

	always_ff @(posedge clk)
	begin
		if (lookup.hit)
			dat_r <= line_mem[lookup.hit_way][lookup.set_index][word_sel];
		else
			dat_r <= '0; // a miss reads as zero
	end

endmodule

/* hdl/victim_select.sv */
// replacement way choice over the enabled ways of the indexed set, combinational
module victim_select (
	input  cache_pkg::assoc_mode_t             assoc_mode,
	input  cache_pkg::way_state_t              ways,
	output logic [cache_pkg::way_idx_bits-1:0] victim_way
);

	logic [cache_pkg::num_ways-1:0]   en;
	logic                             found_free;
	logic [cache_pkg::count_bits-1:0] best_count;

	assign en = cache_pkg::enabled_ways(assoc_mode);

	always_comb
	begin
		found_free = 1'b0;
		victim_way = '0;
		best_count = '1;
		// first invalid way takes priority
		for (int w = 0; w < cache_pkg::num_ways; w++)
		begin
			if (en[w] && !ways[w].valid && !found_free)
			begin
				victim_way = cache_pkg::way_idx_bits'(w);
				found_free = 1'b1;
			end
		end
		if (!found_free)
		begin
			// way 0 is always enabled, strict compare keeps ties on the lowest way
			best_count = ways[0].use_count;
			for (int w = 1; w < cache_pkg::num_ways; w++)
			begin
				if (en[w] && ways[w].use_count < best_count)
				begin
					victim_way = cache_pkg::way_idx_bits'(w);
					best_count = ways[w].use_count;
				end
			end
		end
	end

endmodule

/* hdl/tag_store.sv */
// valid, tag and use-count arrays of all ways with per-mode index decode and hit detection
module tag_store (
	input  logic                   clk,
	input  logic                   reset,
	input  cache_pkg::assoc_mode_t assoc_mode,
	input  cache_pkg::cache_addr_u req_addr,
	input  cache_pkg::update_t     update,
	output cache_pkg::lookup_t     lookup,
	output cache_pkg::way_state_t  ways
);

	logic [cache_pkg::tag_bits-1:0]   tag_mem   [cache_pkg::num_ways][cache_pkg::lines_per_way];
	logic [cache_pkg::count_bits-1:0] count_mem [cache_pkg::num_ways][cache_pkg::lines_per_way];

	// valid bits live in flops so reset clears them in one cycle
	logic [cache_pkg::num_ways-1:0][cache_pkg::lines_per_way-1:0] valid_q;

	logic [cache_pkg::line_idx_bits-1:0] set_idx;
	logic [cache_pkg::tag_bits-1:0]      req_tag;
	logic [cache_pkg::num_ways-1:0]      en;
	logic [cache_pkg::num_ways-1:0]      match_vec;
	logic [cache_pkg::way_idx_bits-1:0]  match_way;

	assign en = cache_pkg::enabled_ways(assoc_mode);

	always_comb
	begin
		case (assoc_mode)
			cache_pkg::mode_1way:
			begin
				set_idx = req_addr.v1.set_index;
				req_tag = cache_pkg::tag_bits'(req_addr.v1.tag);
			end
			cache_pkg::mode_2way:
			begin
				set_idx = cache_pkg::line_idx_bits'(req_addr.v2.set_index);
				req_tag = cache_pkg::tag_bits'(req_addr.v2.tag);
			end
			cache_pkg::mode_4way:
			begin
				set_idx = cache_pkg::line_idx_bits'(req_addr.v4.set_index);
				req_tag = cache_pkg::tag_bits'(req_addr.v4.tag);
			end
			default:
			begin
				set_idx = cache_pkg::line_idx_bits'(req_addr.v8.set_index);
				req_tag = cache_pkg::tag_bits'(req_addr.v8.tag);
			end
		endcase
	end

	always_comb
	begin
		match_way = '0;
		for (int w = cache_pkg::num_ways - 1; w >= 0; w--)
		begin
			match_vec[w] = en[w] && valid_q[w][set_idx] && (tag_mem[w][set_idx] == req_tag);
			if (match_vec[w])
				match_way = cache_pkg::way_idx_bits'(w); // lowest way wins if several
		end
	end

	always_ff @(posedge clk)
	begin
		if (!reset)
		begin
			valid_q <= '0;
			lookup  <= '0;
		end
		else
		begin
			if (update.do_update && update.fill)
				valid_q[update.way][set_idx] <= 1'b1;
			lookup.hit       <= |match_vec;
			lookup.hit_way   <= match_way;
			lookup.set_index <= set_idx;
		end
	end

	// registered view of the indexed set for replacement
	always_ff @(posedge clk)
	begin
		for (int w = 0; w < cache_pkg::num_ways; w++)
		begin
			ways[w].valid     <= valid_q[w][set_idx];
			ways[w].tag       <= tag_mem[w][set_idx];
			ways[w].use_count <= count_mem[w][set_idx];
		end
	end

	always_ff @(posedge clk)
	begin
		if (update.do_update)
		begin
			if (update.fill)
			begin
				tag_mem[update.way][set_idx]   <= req_tag;
				count_mem[update.way][set_idx] <= cache_pkg::count_bits'(1);
			end
			else if (count_mem[update.way][set_idx] != '1)
				count_mem[update.way][set_idx] <= count_mem[update.way][set_idx] + 1'b1;
		end
	end

	// the controller only allocates on a miss, so a tag is never resident twice in a set
	single_match: assert property (@(posedge clk) disable iff (!reset) $onehot0(match_vec));

endmodule

/* hdl/cache_ctrl.sv */
// Wishbone classic slave FSM that sequences lookup, update and acknowledge for each request
module cache_ctrl (
	input  logic                                  clk,
	input  logic                                  reset,
	input  logic                                  cyc,
	input  logic                                  stb,
	input  logic                                  we,
	input  logic [31:0]                           adr,
	input  logic [31:0]                           dat_w,
	output logic                                  ack,
	output logic                                  hit,
	output logic                                  miss,
	output cache_pkg::cache_addr_u                req_addr,
	output logic [cache_pkg::word_bits-1:0]       req_data,
	input  cache_pkg::lookup_t                    lookup,
	input  logic [cache_pkg::way_idx_bits-1:0]    victim_way,
	output cache_pkg::update_t                    update
);

	typedef enum logic [1:0] {
		st_idle,
		st_lookup,  // arrays read this cycle
		st_compare, // registered lookup result is valid
		st_fill     // allocate the victim line
	} state_t;

	state_t state;
	logic   req_we;

	// the ack cycle still shows stb, so a new request waits for ack to fall
	always_ff @(posedge clk)
	begin
		if (!reset)
		begin
			state <= st_idle;
			ack   <= 1'b0;
			hit   <= 1'b0;
			miss  <= 1'b0;
		end
		else
		begin
			ack  <= 1'b0;
			hit  <= 1'b0;
			miss <= 1'b0;
			case (state)
				st_idle:
				begin
					if (cyc && stb && !ack)
						state <= st_lookup;
				end
				st_lookup:
					state <= st_compare;
				st_compare:
				begin
					if (lookup.hit)
					begin
						ack   <= 1'b1;
						hit   <= 1'b1;
						state <= st_idle;
					end
					else
						state <= st_fill;
				end
				st_fill:
				begin
					ack   <= 1'b1;
					miss  <= 1'b1;
					state <= st_idle;
				end
				default:
					state <= st_idle;
			endcase
		end
	end

	// request payload, held until the next accepted request
	always_ff @(posedge clk)
	begin
		if (state == st_idle && cyc && stb && !ack)
		begin
			req_addr.raw <= adr;
			req_data     <= dat_w;
			req_we       <= we;
		end
	end

	always_comb
	begin
		update = '0;
		if (state == st_compare && lookup.hit)
		begin
			update.do_update = 1'b1; // count bump, word write if we
			update.way       = lookup.hit_way;
			update.we        = req_we;
		end
		else if (state == st_fill)
		begin
			update.do_update = 1'b1;
			update.fill      = 1'b1;
			update.way       = victim_way;
			update.we        = req_we;
		end
	end

	// one request in flight, so acks are always separated
	ack_single: assert property (@(posedge clk) disable iff (!reset) ack |=> !ack);

	hit_miss_excl: assert property (@(posedge clk) disable iff (!reset) !(hit && miss));

endmodule

/* hdl/cache_pkg.sv */
// cache geometry, address views and the structs shared by every block of the cache
package cache_pkg;

	localparam int num_ways       = 8;
	localparam int lines_per_way  = 64;
	localparam int words_per_line = 4;
	localparam int word_bits      = 32;
	localparam int way_idx_bits   = 3;
	localparam int line_idx_bits  = 6;
	localparam int count_bits     = 4;  // saturates at 15
	localparam int tag_bits       = 26; // stored tag width, narrower tags are zero-padded

	typedef enum logic [1:0] {
		mode_1way = 2'd0,
		mode_2way = 2'd1,
		mode_4way = 2'd2,
		mode_8way = 2'd3
	} assoc_mode_t;

	// one view per mode, the set index shrinks as the tag grows
	typedef struct packed {
		logic [21:0] tag;
		logic [5:0]  set_index;
		logic [1:0]  word_off;
		logic [1:0]  byte_sel;
	} addr_1way_t;

	typedef struct packed {
		logic [22:0] tag;
		logic [4:0]  set_index;
		logic [1:0]  word_off;
		logic [1:0]  byte_sel;
	} addr_2way_t;

	typedef struct packed {
		logic [23:0] tag;
		logic [3:0]  set_index;
		logic [1:0]  word_off;
		logic [1:0]  byte_sel;
	} addr_4way_t;

	typedef struct packed {
		logic [24:0] tag;
		logic [2:0]  set_index;
		logic [1:0]  word_off;
		logic [1:0]  byte_sel;
	} addr_8way_t;

	typedef union packed {
		logic [31:0] raw;
		addr_1way_t  v1;
		addr_2way_t  v2;
		addr_4way_t  v4;
		addr_8way_t  v8;
	} cache_addr_u;

	typedef struct packed {
		logic                     hit;
		logic [way_idx_bits-1:0]  hit_way;
		logic [line_idx_bits-1:0] set_index; // zero-padded in the wider modes
	} lookup_t;

	typedef struct packed {
		logic                  valid;
		logic [tag_bits-1:0]   tag;
		logic [count_bits-1:0] use_count;
	} line_state_t;

	typedef line_state_t [num_ways-1:0] way_state_t;

	typedef struct packed {
		logic                    do_update;
		logic                    fill; // allocate the line instead of a hit update
		logic [way_idx_bits-1:0] way;
		logic                    we;
	} update_t;

	// ways that take part in lookup and replacement
	function automatic logic [num_ways-1:0] enabled_ways(input assoc_mode_t mode);
		case (mode)
			mode_1way: return 8'b0000_0001;
			mode_2way: return 8'b0000_0011;
			mode_4way: return 8'b0000_1111;
			default:   return 8'b1111_1111;
		endcase
	endfunction

endpackage
